// ==== rtl/flash_audio_pkg.sv ====
package flash_audio_pkg;

  // ==========================================================================
  // Flash bus and audio data types
  // ==========================================================================

  // Word address into the song
  typedef logic [22:0] flash_addr_t;

  typedef logic [31:0] flash_word_t;

  typedef logic signed [7:0] audio_sample_t;

  // Byte lane inside a flash word, lane 0 is bits 7:0
  typedef logic [1:0] byte_idx_t;

  // Master side of the read bus
  typedef struct packed
  {
    logic        read;
    flash_addr_t address;
  } flash_req_t;

  // Flash side of the read bus
  typedef struct packed
  {
    logic        waitrequest;
    logic        readdatavalid;
    flash_word_t readdata;
  } flash_rsp_t;

endpackage

// ==== rtl/flash_word_fetch.sv ====
`timescale 1ns/1ps

module flash_word_fetch #(
  parameter flash_audio_pkg::flash_addr_t LAST_ADDR = 23'h7FFFF
) (
  input  logic                        CLK_50M,
  input  logic                        rst,
  input  logic                        fetch_start,
  input  logic                        dir_backward,
  input  logic                        restart,
  output flash_audio_pkg::flash_req_t flash_req,
  input  flash_audio_pkg::flash_rsp_t flash_rsp,
  output logic                        word_valid,
  output flash_audio_pkg::flash_word_t word
);

  import flash_audio_pkg::*;

  flash_addr_t addr;
  flash_addr_t step_addr;
  flash_addr_t restart_addr;
  logic        req_read;
  logic        waiting;
  logic        restart_pend;
  logic        accepted;
  logic        rd_done;
  logic        discard;

  // Wrapping song pointer
  always_comb
  begin
    if (dir_backward)
      step_addr = (addr == '0) ? LAST_ADDR : addr - 23'd1;
    else
      step_addr = (addr == LAST_ADDR) ? '0 : addr + 23'd1;
  end

  assign restart_addr = dir_backward ? LAST_ADDR : '0;
  assign accepted     = req_read && !flash_rsp.waitrequest;
  assign rd_done      = waiting && flash_rsp.readdatavalid;
  assign discard      = restart_pend || restart;

  assign flash_req.read    = req_read;
  assign flash_req.address = addr;

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      addr         <= '0;
      req_read     <= 1'b0;
      waiting      <= 1'b0;
      restart_pend <= 1'b0;
      word_valid   <= 1'b0;
    end
    else
    begin
      word_valid <= 1'b0;
      if (accepted)
      begin
        req_read <= 1'b0;
        waiting  <= 1'b1;
        addr     <= step_addr;
      end
      if (rd_done)
      begin
        waiting <= 1'b0;
        // Stale word after a restart, read again from the new position
        if (discard)
        begin
          restart_pend <= 1'b0;
          addr         <= restart_addr;
          req_read     <= 1'b1;
        end
        else
          word_valid <= 1'b1;
      end
      else if (restart)
      begin
        if (req_read || waiting)
          restart_pend <= 1'b1;
        else
          addr <= restart_addr;
      end
      if (fetch_start)
        req_read <= 1'b1;
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (rd_done && !discard)
      word <= flash_rsp.readdata;
  end

endmodule

// ==== rtl/ipod_top.sv ====
`timescale 1ns/1ps

module ipod_top #(
  parameter player_ctrl_pkg::tick_div_t  DEFAULT_DIV = 16'd2272,
  parameter player_ctrl_pkg::tick_div_t  SPEED_STEP  = 16'd100,
  parameter player_ctrl_pkg::tick_div_t  MIN_DIV     = 16'd568,
  parameter player_ctrl_pkg::tick_div_t  MAX_DIV     = 16'd9088,
  parameter flash_audio_pkg::flash_addr_t LAST_ADDR  = 23'h7FFFF
) (
  input  logic                          CLK_50M,
  input  logic                          rst,
  input  logic                          cmd_valid,
  input  player_ctrl_pkg::player_cmd_t  cmd,
  output flash_audio_pkg::flash_req_t   flash_req,
  input  flash_audio_pkg::flash_rsp_t   flash_rsp,
  output flash_audio_pkg::audio_sample_t sample,
  output logic                          sample_valid
);

  import player_ctrl_pkg::*;
  import flash_audio_pkg::*;

  speed_adj_t  speed_adj;
  logic        sample_tick;
  logic        fetch_start;
  logic        dir_backward;
  logic        restart;
  logic        play_en;
  logic        need_word;
  logic        word_valid;
  flash_word_t word;

  player_fsm i_player_fsm (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .cmd_valid    (cmd_valid),
    .cmd          (cmd),
    .word_valid   (word_valid),
    .need_word    (need_word),
    .speed_adj    (speed_adj),
    .fetch_start  (fetch_start),
    .dir_backward (dir_backward),
    .restart      (restart),
    .play_en      (play_en)
  );

  sample_rate_gen #(
    .DEFAULT_DIV (DEFAULT_DIV),
    .SPEED_STEP  (SPEED_STEP),
    .MIN_DIV     (MIN_DIV),
    .MAX_DIV     (MAX_DIV)
  ) i_sample_rate_gen (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .speed_adj   (speed_adj),
    .sample_tick (sample_tick)
  );

  flash_word_fetch #(
    .LAST_ADDR (LAST_ADDR)
  ) i_flash_word_fetch (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .fetch_start  (fetch_start),
    .dir_backward (dir_backward),
    .restart      (restart),
    .flash_req    (flash_req),
    .flash_rsp    (flash_rsp),
    .word_valid   (word_valid),
    .word         (word)
  );

  sample_unpacker i_sample_unpacker (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .word_valid   (word_valid),
    .word         (word),
    .dir_backward (dir_backward),
    .sample_tick  (sample_tick),
    .play_en      (play_en),
    .need_word    (need_word),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

endmodule

// ==== rtl/player_ctrl_pkg.sv ====
package player_ctrl_pkg;

  // ==========================================================================
  // Player commands and control state
  // ==========================================================================

  typedef enum logic [2:0]
  {
    CMD_PLAY        = 3'd0,
    CMD_PAUSE       = 3'd1,
    CMD_FORWARD     = 3'd2,
    CMD_BACKWARD    = 3'd3,
    CMD_RESTART     = 3'd4,
    CMD_SPEED_UP    = 3'd5,
    CMD_SPEED_DOWN  = 3'd6,
    CMD_SPEED_RESET = 3'd7
  } player_cmd_t;

  typedef enum logic [1:0]
  {
    ST_PAUSED  = 2'd0,
    ST_LOAD    = 2'd1,
    ST_PLAYING = 2'd2
  } player_state_t;

  // One-cycle pulses towards the sample rate divider
  typedef struct packed
  {
    logic up;
    logic down;
    logic reset;
  } speed_adj_t;

  // Clocks per sample period
  typedef logic [15:0] tick_div_t;

endpackage

// ==== rtl/player_fsm.sv ====
`timescale 1ns/1ps

module player_fsm (
  input  logic                         CLK_50M,
  input  logic                         rst,
  input  logic                         cmd_valid,
  input  player_ctrl_pkg::player_cmd_t cmd,
  input  logic                         word_valid,
  input  logic                         need_word,
  output player_ctrl_pkg::speed_adj_t  speed_adj,
  output logic                         fetch_start,
  output logic                         dir_backward,
  output logic                         restart,
  output logic                         play_en
);

  import player_ctrl_pkg::*;

  player_state_t state;
  logic          fetch_pending;
  logic          play_now;
  logic          pause_now;

  assign play_now  = cmd_valid && (cmd == CMD_PLAY);
  assign pause_now = cmd_valid && (cmd == CMD_PAUSE);

  // A pause also blocks a tick landing in the command cycle
  assign play_en = (state == ST_PLAYING) && !pause_now;

  // ==========================================================================
  // Play state and word requests
  // ==========================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state         <= ST_PAUSED;
      fetch_start   <= 1'b0;
      fetch_pending <= 1'b0;
    end
    else
    begin
      fetch_start <= 1'b0;
      if (word_valid)
        fetch_pending <= 1'b0;

      case (state)
        ST_PAUSED:
          if (play_now)
          begin
            // Unpacker empty, so a word must arrive first
            if (need_word && !word_valid)
            begin
              state <= ST_LOAD;
              if (!fetch_pending)
              begin
                fetch_start   <= 1'b1;
                fetch_pending <= 1'b1;
              end
            end
            else
              state <= ST_PLAYING;
          end
        ST_LOAD:
          if (pause_now)
            state <= ST_PAUSED;
          else if (word_valid)
            state <= ST_PLAYING;
        ST_PLAYING:
          if (pause_now)
            state <= ST_PAUSED;
          else if (need_word && !fetch_pending)
          begin
            fetch_start   <= 1'b1;
            fetch_pending <= 1'b1;
          end
        default:
          state <= ST_PAUSED;
      endcase
    end
  end

  // ==========================================================================
  // Direction, restart and speed pulses
  // ==========================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      dir_backward <= 1'b0;
      restart      <= 1'b0;
      speed_adj    <= '0;
    end
    else
    begin
      restart   <= 1'b0;
      speed_adj <= '0;
      if (cmd_valid)
      begin
        case (cmd)
          CMD_FORWARD:
            if (dir_backward)
            begin
              dir_backward <= 1'b0;
              restart      <= 1'b1;
            end
          CMD_BACKWARD:
            if (!dir_backward)
            begin
              dir_backward <= 1'b1;
              restart      <= 1'b1;
            end
          CMD_RESTART:     restart         <= 1'b1;
          CMD_SPEED_UP:    speed_adj.up    <= 1'b1;
          CMD_SPEED_DOWN:  speed_adj.down  <= 1'b1;
          CMD_SPEED_RESET: speed_adj.reset <= 1'b1;
          default: ;
        endcase
      end
    end
  end

endmodule

// ==== rtl/sample_rate_gen.sv ====
`timescale 1ns/1ps

module sample_rate_gen #(
  parameter player_ctrl_pkg::tick_div_t DEFAULT_DIV = 16'd2272,
  parameter player_ctrl_pkg::tick_div_t SPEED_STEP  = 16'd100,
  parameter player_ctrl_pkg::tick_div_t MIN_DIV     = 16'd568,
  parameter player_ctrl_pkg::tick_div_t MAX_DIV     = 16'd9088
) (
  input  logic                        CLK_50M,
  input  logic                        rst,
  input  player_ctrl_pkg::speed_adj_t speed_adj,
  output logic                        sample_tick
);

  import player_ctrl_pkg::*;

  tick_div_t div;
  tick_div_t next_div;
  tick_div_t count;

  // Saturating period update
  always_comb
  begin
    next_div = div;
    if (speed_adj.reset)
      next_div = DEFAULT_DIV;
    else if (speed_adj.up)
      next_div = (div < MIN_DIV + SPEED_STEP) ? MIN_DIV : div - SPEED_STEP;
    else if (speed_adj.down)
      next_div = (div > MAX_DIV - SPEED_STEP) ? MAX_DIV : div + SPEED_STEP;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      div   <= DEFAULT_DIV;
      count <= DEFAULT_DIV - 16'd1;
    end
    else if (speed_adj.up || speed_adj.down || speed_adj.reset)
    begin
      // New period starts counting right away
      div   <= next_div;
      count <= next_div - 16'd1;
    end
    else if (count == '0)
      count <= div - 16'd1;
    else
      count <= count - 16'd1;
  end

  assign sample_tick = (count == '0);

endmodule

// ==== rtl/sample_unpacker.sv ====
`timescale 1ns/1ps

module sample_unpacker (
  input  logic                          CLK_50M,
  input  logic                          rst,
  input  logic                          word_valid,
  input  flash_audio_pkg::flash_word_t  word,
  input  logic                          dir_backward,
  input  logic                          sample_tick,
  input  logic                          play_en,
  output logic                          need_word,
  output flash_audio_pkg::audio_sample_t sample,
  output logic                          sample_valid
);

  import flash_audio_pkg::*;

  flash_word_t word_q;
  byte_idx_t   idx;
  logic [2:0]  remain;
  logic        word_bwd;
  logic        release_now;

  // Ticks with nothing held are dropped, playback just stalls
  assign release_now = sample_tick && play_en && (remain != 3'd0);
  assign need_word   = (remain == 3'd0) || (release_now && (remain == 3'd1));

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      remain       <= 3'd0;
      idx          <= '0;
      word_bwd     <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= release_now;
      if (release_now)
      begin
        idx    <= word_bwd ? idx - 2'd1 : idx + 2'd1;
        remain <= remain - 3'd1;
      end
      // Byte order is fixed by the direction at load time
      if (word_valid)
      begin
        remain   <= 3'd4;
        idx      <= dir_backward ? 2'd3 : 2'd0;
        word_bwd <= dir_backward;
      end
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (word_valid)
      word_q <= word;
    if (release_now)
      sample <= audio_sample_t'(word_q[8 * idx +: 8]);
  end

endmodule

// ==== simple_ipod.f ====
rtl/player_ctrl_pkg.sv
rtl/flash_audio_pkg.sv
rtl/player_fsm.sv
rtl/sample_rate_gen.sv
rtl/flash_word_fetch.sv
rtl/sample_unpacker.sv
rtl/ipod_top.sv
testbench/tb_flash_model.sv
testbench/tb_ipod_assert.sv
testbench/tb_ipod.sv

// ==== testbench/tb_flash_model.sv ====
`timescale 1ns/1ps

module tb_flash_model (
  input  logic                        CLK_50M,
  input  logic                        rst,
  input  flash_audio_pkg::flash_req_t flash_req,
  output flash_audio_pkg::flash_rsp_t flash_rsp
);

  import flash_audio_pkg::*;

  flash_word_t mem [0:15];
  integer      seed;
  logic [1:0]  stall_cnt;
  logic [1:0]  lat_cnt;
  logic        busy;
  logic [3:0]  addr_q;
  logic        rsp_valid;
  flash_word_t rsp_data;

  initial
  begin
    seed = 3;
    for (int i = 0; i < 16; i++)
      mem[i] = $random(seed);
  end

  // Waitrequest stays high for 0 to 3 cycles of each new request
  assign flash_rsp = {(stall_cnt != 2'd0), rsp_valid, rsp_data};

  always @(posedge CLK_50M)
  begin : bus_model
    integer rnd;
    if (rst)
    begin
      stall_cnt <= 2'd0;
      lat_cnt   <= 2'd0;
      busy      <= 1'b0;
      rsp_valid <= 1'b0;
      rsp_data  <= '0;
    end
    else
    begin
      rsp_valid <= 1'b0;
      if (busy)
      begin
        if (lat_cnt == 2'd0)
        begin
          busy      <= 1'b0;
          rsp_valid <= 1'b1;
          rsp_data  <= mem[addr_q];
        end
        else
          lat_cnt <= lat_cnt - 2'd1;
      end
      else if (flash_req.read && stall_cnt == 2'd0)
      begin
        // Accepted, latency of 1 to 4 cycles
        rnd       = $random(seed);
        stall_cnt <= rnd[3:2];
        addr_q    <= flash_req.address[3:0];
        if (rnd[1:0] == 2'd0)
        begin
          rsp_valid <= 1'b1;
          rsp_data  <= mem[flash_req.address[3:0]];
        end
        else
        begin
          busy    <= 1'b1;
          lat_cnt <= rnd[1:0] - 2'd1;
        end
      end
      else if (flash_req.read && stall_cnt != 2'd0)
        stall_cnt <= stall_cnt - 2'd1;
    end
  end

endmodule

// ==== testbench/tb_ipod.sv ====
`timescale 1ns/1ps

module tb_ipod;

  import player_ctrl_pkg::*;
  import flash_audio_pkg::*;

  // About 200 samples at 12 clocks plus flash latency, with a wide margin
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int LAST_WORD      = 15;

  logic          CLK_50M = 1'b0;
  logic          rst;
  logic          cmd_valid;
  player_cmd_t   cmd;
  flash_req_t    flash_req;
  flash_rsp_t    flash_rsp;
  audio_sample_t sample;
  logic          sample_valid;

  // Reference pointer and timing state
  int          cycle = 0;
  int          cmd_count = 0;
  int          cmds_prev = 0;
  int          last_cycle = 0;
  int          left = 0;
  int          exp_div = 12;
  int          next_addr = 0;
  int          cur_addr = 0;
  byte_idx_t   cur_idx = '0;
  logic        cur_bwd = 1'b0;
  logic        dir = 1'b0;
  string       test_name = "reset";

  always #10 CLK_50M = ~CLK_50M;

  ipod_top #(
    .DEFAULT_DIV (16'd12),
    .SPEED_STEP  (16'd2),
    .MIN_DIV     (16'd4),
    .MAX_DIV     (16'd40),
    .LAST_ADDR   (23'd15)
  ) i_dut (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .cmd_valid    (cmd_valid),
    .cmd          (cmd),
    .flash_req    (flash_req),
    .flash_rsp    (flash_rsp),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  tb_flash_model i_flash (
    .CLK_50M   (CLK_50M),
    .rst       (rst),
    .flash_req (flash_req),
    .flash_rsp (flash_rsp)
  );

  function automatic int step_addr(input int addr, input logic bwd);
    if (bwd)
      return (addr == 0) ? LAST_WORD : addr - 1;
    return (addr == LAST_WORD) ? 0 : addr + 1;
  endfunction

  task automatic report_value(input string what, input int expected, input int actual);
    $display("CHECK FAILED %s (%s): expected %0d, actual %0d", test_name, what,
             expected, actual);
    $display("RESULT: FAIL");
    $fatal(1, "value mismatch");
  endtask

  // ==========================================================================
  // Sample checker
  // ==========================================================================
  always @(posedge CLK_50M)
  begin : check_sample
    int          a;
    int          remain;
    byte_idx_t   i;
    logic        bwd;
    logic [7:0]  exp_byte;
    if (!rst && sample_valid)
    begin
      if (left == 0)
      begin
        // New word, order follows the direction at load time
        a      = next_addr;
        bwd    = dir;
        i      = dir ? 2'd3 : 2'd0;
        remain = 4;
        next_addr <= step_addr(next_addr, dir);
      end
      else
      begin
        a      = cur_addr;
        bwd    = cur_bwd;
        i      = cur_idx;
        remain = left;
      end
      exp_byte = i_flash.mem[a][8 * i +: 8];
      assert (sample === exp_byte)
      else
        report_value("sample byte", exp_byte, $unsigned(sample));
      if (left != 0 && cmd_count == cmds_prev)
        assert (cycle - last_cycle == exp_div)
        else
          report_value("sample period", exp_div, cycle - last_cycle);
      cur_addr   <= a;
      cur_bwd    <= bwd;
      cur_idx    <= bwd ? i - 2'd1 : i + 2'd1;
      left       <= remain - 1;
      last_cycle <= cycle;
      cmds_prev  <= cmd_count;
    end
  end

  // Cycle count, timeout and assertion watch
  always @(posedge CLK_50M)
  begin
    cycle <= cycle + 1;
    if (i_dut.i_ipod_assert.fail_count != 0)
    begin
      $display("Bus or control assertion failed during %s", test_name);
      $display("RESULT: FAIL");
      $fatal(1, "assertion failure");
    end
    else if (cycle >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles during %s", cycle, test_name);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  // Called on a rising edge, holds the command for one cycle
  task automatic send_cmd(input player_cmd_t c);
    cmd       <= c;
    cmd_valid <= 1'b1;
    cmd_count <= cmd_count + 1;
    case (c)
      CMD_FORWARD:
        if (dir)
        begin
          dir       <= 1'b0;
          next_addr <= 0;
        end
      CMD_BACKWARD:
        if (!dir)
        begin
          dir       <= 1'b1;
          next_addr <= LAST_WORD;
        end
      CMD_RESTART:     next_addr <= dir ? LAST_WORD : 0;
      CMD_SPEED_UP:    exp_div <= (exp_div - 2 < 4) ? 4 : exp_div - 2;
      CMD_SPEED_DOWN:  exp_div <= (exp_div + 2 > 40) ? 40 : exp_div + 2;
      CMD_SPEED_RESET: exp_div <= 12;
      default: ;
    endcase
    @(posedge CLK_50M);
    cmd_valid <= 1'b0;
  endtask

  // Returns on an edge where a sample leaves bytes of its word still held
  task automatic wait_mid_word();
    do
      @(posedge CLK_50M);
    while (!(sample_valid && left >= 2));
  endtask

  task automatic wait_samples(input int n);
    int k;
    k = 0;
    while (k < n)
    begin
      @(posedge CLK_50M);
      if (sample_valid)
        k++;
    end
  endtask

  initial
  begin
    rst       = 1'b1;
    cmd_valid = 1'b0;
    cmd       = CMD_PLAY;
    repeat (16) @(posedge CLK_50M);
    rst <= 1'b0;
    repeat (4) @(posedge CLK_50M);

    test_name = "forward playback";
    send_cmd(CMD_PLAY);
    wait_samples(70);

    test_name = "backward playback";
    wait_mid_word();
    send_cmd(CMD_BACKWARD);
    wait_samples(72);
    test_name = "restart backward";
    wait_mid_word();
    send_cmd(CMD_RESTART);
    wait_samples(10);

    test_name = "pause";
    wait_mid_word();
    send_cmd(CMD_PAUSE);
    repeat (100) @(posedge CLK_50M);
    send_cmd(CMD_PLAY);
    wait_samples(10);

    test_name = "speed";
    wait_mid_word();
    send_cmd(CMD_SPEED_UP);
    send_cmd(CMD_SPEED_UP);
    wait_samples(12);
    wait_mid_word();
    send_cmd(CMD_SPEED_UP);
    send_cmd(CMD_SPEED_UP);
    send_cmd(CMD_SPEED_UP);
    wait_samples(12);
    wait_mid_word();
    send_cmd(CMD_SPEED_RESET);
    wait_samples(12);

    test_name = "forward again";
    wait_mid_word();
    send_cmd(CMD_FORWARD);
    wait_samples(10);

    repeat (4) @(posedge CLK_50M);
    if (i_dut.i_ipod_assert.fail_count != 0)
    begin
      $display("Bus or control assertion failed");
      $display("RESULT: FAIL");
      $fatal(1, "assertion failure");
    end
    else
    begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== testbench/tb_ipod_assert.sv ====
`timescale 1ns/1ps

module ipod_assert (
  input logic                          CLK_50M,
  input logic                          rst,
  input flash_audio_pkg::flash_req_t   flash_req,
  input flash_audio_pkg::flash_rsp_t   flash_rsp,
  input logic                          sample_valid,
  input player_ctrl_pkg::player_state_t state
);

  import player_ctrl_pkg::*;

  int   fail_count = 0;
  logic outstanding;

  // One read in flight between acceptance and readdatavalid
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      outstanding <= 1'b0;
    else if (flash_req.read && !flash_rsp.waitrequest)
      outstanding <= 1'b1;
    else if (flash_rsp.readdatavalid)
      outstanding <= 1'b0;
  end

  a_req_stable: assert property (@(posedge CLK_50M) disable iff (rst)
    flash_req.read && flash_rsp.waitrequest |=> flash_req.read && $stable(flash_req.address))
  else
  begin
    $error("read or address changed while waitrequest was high");
    fail_count++;
  end

  a_one_outstanding: assert property (@(posedge CLK_50M) disable iff (rst)
    outstanding |-> !flash_req.read)
  else
  begin
    $error("new read started while a read was outstanding");
    fail_count++;
  end

  a_reset_release: assert property (@(posedge CLK_50M)
    $fell(rst) |-> !flash_req.read && !sample_valid)
  else
  begin
    $error("read or sample_valid high right after reset");
    fail_count++;
  end

  a_paused_quiet: assert property (@(posedge CLK_50M) disable iff (rst)
    (state == ST_PAUSED) |-> !sample_valid)
  else
  begin
    $error("sample_valid high while paused");
    fail_count++;
  end

endmodule

bind ipod_top ipod_assert i_ipod_assert (
  .CLK_50M      (CLK_50M),
  .rst          (rst),
  .flash_req    (flash_req),
  .flash_rsp    (flash_rsp),
  .sample_valid (sample_valid),
  .state        (i_player_fsm.state)
);
